// File: src/arith_pkg.sv
// Number formats shared by the MAC elements, the drain path and the result scaler
`default_nettype none

package arith_pkg;

  // Weights and activations are signed bytes
  localparam int OPERAND_WIDTH = 8;

  // Accumulators are wide enough that a long activation stream cannot wrap in practice
  localparam int ACC_WIDTH = 32;

  // Scaled results are signed bytes again, ready to be packed four to a word
  localparam int RESULT_WIDTH = 8;

  // Fixed scale applied to every accumulator before saturation
  localparam int RESULT_SHIFT = 2;

  // Clamp limits of the result format, held at accumulator width for direct comparison
  localparam logic signed [ACC_WIDTH-1:0] RESULT_MAX = (1 <<< (RESULT_WIDTH - 1)) - 1;
  localparam logic signed [ACC_WIDTH-1:0] RESULT_MIN = -RESULT_MAX - 1;

endpackage

`default_nettype wire

// File: src/array_pkg.sv
// Geometry of the processing element row and the layout of the packed output word
`default_nettype none

package array_pkg;

  // Number of processing elements chained in the row
  localparam int NUM_PE = 4;

  // Results packed into one output word
  // One word per drain, so this matches the row length
  localparam int PACKING = NUM_PE;

  // Width of the packed output word
  localparam int WORD_WIDTH = PACKING * arith_pkg::RESULT_WIDTH;

  // The packed word is built lane by lane but leaves the design as one raw word
  // Lane 3 sits in the top byte and carries the result of the element nearest the output
  typedef union packed {
    logic [WORD_WIDTH-1:0] raw;
    logic signed [PACKING-1:0][arith_pkg::RESULT_WIDTH-1:0] lane;
  } result_word_u;

endpackage

`default_nettype wire

// File: src/mac_pe.sv
// One multiply-accumulate element of the row, chained through its weight, activation and drain links
`default_nettype none

module mac_pe (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  ena,
  input  logic                                  w_shift,
  input  logic signed [arith_pkg::OPERAND_WIDTH-1:0] w_in,
  input  logic                                  a_valid,
  input  logic signed [arith_pkg::OPERAND_WIDTH-1:0] a_in,
  input  logic                                  drain_shift,
  input  logic signed [arith_pkg::ACC_WIDTH-1:0]     acc_in,
  output logic signed [arith_pkg::OPERAND_WIDTH-1:0] w_out,
  output logic                                  a_valid_out,
  output logic signed [arith_pkg::OPERAND_WIDTH-1:0] a_out,
  output logic signed [arith_pkg::ACC_WIDTH-1:0]     acc_out
);

  import arith_pkg::*;

  logic signed [OPERAND_WIDTH-1:0]   w_q;
  logic signed [OPERAND_WIDTH-1:0]   a_q;
  logic                              a_valid_q;
  logic signed [ACC_WIDTH-1:0]       acc_q;
  logic signed [2*OPERAND_WIDTH-1:0] prod;

  // The element multiplies the activation it forwards, so the product lines up
  // with the same activation one element further down the row
  assign prod = a_q * w_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      w_q       <= '0;
      a_valid_q <= 1'b0;
      acc_q     <= '0;
    end else if (ena) begin
      // Weight loading is a plain shift register along the row
      if (w_shift) begin
        w_q <= w_in;
      end
      a_valid_q <= a_valid;
      // During a drain the accumulators form a shift chain toward the output end
      if (drain_shift) begin
        acc_q <= acc_in;
      end else if (a_valid_q) begin
        acc_q <= acc_q + ACC_WIDTH'(prod);
      end
    end
  end

  // Activation data moves down the row in step with its valid bit
  always_ff @(posedge clk) begin
    if (ena) begin
      a_q <= a_in;
    end
  end

  assign w_out       = w_q;
  assign a_valid_out = a_valid_q;
  assign a_out       = a_q;
  assign acc_out     = acc_q;

  // A drain that starts while products are still in flight would lose one of them
  assert property (@(posedge clk) disable iff (rst) ena && drain_shift |-> !a_valid_q)
    else $error("mac_pe: drain shift collided with a pending multiply-accumulate");

endmodule

`default_nettype wire

// File: src/pe_row.sv
// Row of MAC elements plus the drain sequencer that streams the accumulators out one per cycle
`default_nettype none

module pe_row (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ena,
  input  logic                                w_load,
  input  logic [arith_pkg::OPERAND_WIDTH-1:0] w_data,
  input  logic                                a_valid,
  input  logic [arith_pkg::OPERAND_WIDTH-1:0] a_data,
  input  logic                                drain,
  output logic                                drain_wrreq,
  output logic [arith_pkg::ACC_WIDTH-1:0]     drain_data
);

  import arith_pkg::*;
  import array_pkg::*;

  localparam int CNT_W   = $clog2(NUM_PE);
  localparam int QUIET_W = $clog2(NUM_PE) + 1;

  // Links between neighbouring elements, entry 0 is fed from the row inputs
  logic signed [OPERAND_WIDTH-1:0] w_chain [NUM_PE+1];
  logic signed [OPERAND_WIDTH-1:0] a_chain [NUM_PE+1];
  logic                            v_chain [NUM_PE+1];
  logic signed [ACC_WIDTH-1:0]     acc_chain [NUM_PE+1];

  logic             drain_start;
  logic             drain_active;
  logic [CNT_W-1:0] drain_cnt;
  logic [QUIET_W-1:0] act_quiet;

  assign w_chain[0]   = w_data;
  assign a_chain[0]   = a_data;
  assign v_chain[0]   = a_valid;
  // Zeros follow the data in, which leaves every accumulator cleared after a drain
  assign acc_chain[0] = '0;

  for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
    mac_pe u_pe (
      .clk         (clk),
      .rst         (rst),
      .ena         (ena),
      .w_shift     (w_load),
      .w_in        (w_chain[k]),
      .a_valid     (v_chain[k]),
      .a_in        (a_chain[k]),
      .drain_shift (drain_active),
      .acc_in      (acc_chain[k]),
      .w_out       (w_chain[k+1]),
      .a_valid_out (v_chain[k+1]),
      .a_out       (a_chain[k+1]),
      .acc_out     (acc_chain[k+1])
    );
  end

  // The drain pulse is registered first, then the chain shifts for NUM_PE cycles
  // act_quiet counts enabled cycles since the last activation, saturating at NUM_PE
  always_ff @(posedge clk) begin
    if (rst) begin
      drain_start  <= 1'b0;
      drain_active <= 1'b0;
      drain_cnt    <= '0;
      act_quiet    <= QUIET_W'(NUM_PE);
    end else if (ena) begin
      drain_start <= drain;
      if (drain_start) begin
        drain_active <= 1'b1;
        drain_cnt    <= '0;
      end else if (drain_active) begin
        if (drain_cnt == CNT_W'(NUM_PE - 1)) begin
          drain_active <= 1'b0;
        end
        drain_cnt <= drain_cnt + 1'b1;
      end
      if (a_valid) begin
        act_quiet <= '0;
      end else if (act_quiet != QUIET_W'(NUM_PE)) begin
        act_quiet <= act_quiet + 1'b1;
      end
    end
  end

  // Each strobe presents the accumulator of the last element, PE3 first
  assign drain_wrreq = drain_active;
  assign drain_data  = acc_chain[NUM_PE];

  // The last product reaches PE3 NUM_PE cycles after its activation enters the row
  assert property (@(posedge clk) disable iff (rst)
                   ena && drain |-> act_quiet == QUIET_W'(NUM_PE))
    else $error("pe_row: drain requested before the last activation settled");

  assert property (@(posedge clk) disable iff (rst)
                   ena && (drain_start || drain_active) |-> !drain && !a_valid)
    else $error("pe_row: drain or activation arrived while a drain is in progress");

endmodule

`default_nettype wire

// File: src/result_trunc.sv
// Scales one accumulator down by a fixed shift and saturates it to the result format
`default_nettype none

module result_trunc (
  input  logic [arith_pkg::ACC_WIDTH-1:0]    acc,
  output logic [arith_pkg::RESULT_WIDTH-1:0] result
);

  import arith_pkg::*;

  logic signed [ACC_WIDTH-1:0] shifted;

  // Arithmetic shift keeps the sign, so negative sums round toward minus infinity
  assign shifted = $signed(acc) >>> RESULT_SHIFT;

  // Anything outside the byte range pins to the nearest limit
  always_comb begin
    if (shifted > RESULT_MAX) begin
      result = RESULT_MAX[RESULT_WIDTH-1:0];
    end else if (shifted < RESULT_MIN) begin
      result = RESULT_MIN[RESULT_WIDTH-1:0];
    end else begin
      result = shifted[RESULT_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// File: src/pe_packer.sv
// Gathers the scaled results of one drain into a packed output word and flags it once complete
`default_nettype none

module pe_packer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               ena,
  input  logic                               drain_wrreq,
  input  logic [arith_pkg::ACC_WIDTH-1:0]    drain_data,
  output logic                               out_valid,
  output logic [array_pkg::WORD_WIDTH-1:0]   out_data
);

  import arith_pkg::*;
  import array_pkg::*;

  localparam int PCNT_W = $clog2(PACKING);

  logic [PCNT_W-1:0]       pack_cnt;
  logic [RESULT_WIDTH-1:0] scaled;
  result_word_u            word_q;
  result_word_u            word_out;
  logic                    last_lane;

  result_trunc u_trunc (
    .acc    (drain_data),
    .result (scaled)
  );

  assign last_lane = (pack_cnt == PCNT_W'(PACKING - 1));

  // Count strobes within a drain, wrapping after the last lane
  always_ff @(posedge clk) begin
    if (rst) begin
      pack_cnt <= '0;
    end else if (ena && drain_wrreq) begin
      if (last_lane) begin
        pack_cnt <= '0;
      end else begin
        pack_cnt <= pack_cnt + 1'b1;
      end
    end
  end

  // Results arrive PE3 first, so the first strobe fills the top lane
  // Lane 0 is never stored; the last result goes straight to the output
  always_ff @(posedge clk) begin
    if (rst) begin
      word_q.raw <= '0;
    end else if (ena && drain_wrreq && !last_lane) begin
      word_q.lane[PACKING - 1 - int'(pack_cnt)] <= scaled;
    end
  end

  always_comb begin
    word_out         = word_q;
    word_out.lane[0] = scaled;
  end

  assign out_data = word_out.raw;
  // A word is complete only on the strobe that fills the last lane
  assign out_valid = ena && drain_wrreq && last_lane;

  // A drain delivers exactly PACKING strobes and leaves the count back at zero
  assert property (@(posedge clk) disable iff (rst) !drain_wrreq |-> pack_cnt == '0)
    else $error("pe_packer: pack count out of step with the drain strobes");

endmodule

`default_nettype wire

// File: src/pe_drain_top.sv
// Top level of the drain path, joining the MAC row to the result packer behind plain ports
`default_nettype none

module pe_drain_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                ena,
  input  logic                                w_load,
  input  logic [arith_pkg::OPERAND_WIDTH-1:0] w_data,
  input  logic                                a_valid,
  input  logic [arith_pkg::OPERAND_WIDTH-1:0] a_data,
  input  logic                                drain,
  output logic                                out_valid,
  output logic [array_pkg::WORD_WIDTH-1:0]    out_data
);

  import arith_pkg::*;

  // The drain link is only a strobe and one accumulator per cycle
  logic                 drain_wrreq;
  logic [ACC_WIDTH-1:0] drain_data;

  pe_row u_row (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .w_load      (w_load),
    .w_data      (w_data),
    .a_valid     (a_valid),
    .a_data      (a_data),
    .drain       (drain),
    .drain_wrreq (drain_wrreq),
    .drain_data  (drain_data)
  );

  pe_packer u_packer (
    .clk         (clk),
    .rst         (rst),
    .ena         (ena),
    .drain_wrreq (drain_wrreq),
    .drain_data  (drain_data),
    .out_valid   (out_valid),
    .out_data    (out_data)
  );

endmodule

`default_nettype wire

// File: tests/tb_pe_drain_top.sv
// Testbench for the drain path top level; replays the command file and compares each packed word
`default_nettype none

module tb_pe_drain_top;

  timeunit 1ns;
  timeprecision 100ps;

  import arith_pkg::*;
  import array_pkg::*;

  // Longest wait for one output word, in clock cycles
  localparam int WAIT_LIMIT = 50;

  logic                     clk;
  logic                     rst;
  logic                     ena;
  logic                     w_load;
  logic [OPERAND_WIDTH-1:0] w_data;
  logic                     a_valid;
  logic [OPERAND_WIDTH-1:0] a_data;
  logic                     drain;
  logic                     out_valid;
  logic [WORD_WIDTH-1:0]    out_data;

  string test_name;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;

  pe_drain_top DUT (
    .clk       (clk),
    .rst       (rst),
    .ena       (ena),
    .w_load    (w_load),
    .w_data    (w_data),
    .a_valid   (a_valid),
    .a_data    (a_data),
    .drain     (drain),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Inputs change 1 ns after the rising edge and hold for the rest of the cycle
  task automatic drive_cycle(input logic en, input logic wl, input logic av,
                             input logic dr, input logic [OPERAND_WIDTH-1:0] value);
    @(posedge clk);
    #1;
    ena     = en;
    w_load  = wl;
    a_valid = av;
    drain   = dr;
    w_data  = wl ? value : '0;
    a_data  = av ? value : '0;
  endtask

  // The falling edge is clear of both input changes and register updates
  task automatic expect_quiet(input string what);
    @(negedge clk);
    if (out_valid) begin
      $display("ERROR %s: %s", test_name, what);
      test_errors++;
    end
  endtask

  task automatic close_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d error(s)", test_name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic run_drain(input logic [WORD_WIDTH-1:0] expected, input int stall_cycles);
    int waited;
    int stall_left;
    bit got_word;
    waited     = 0;
    stall_left = stall_cycles;
    got_word   = 1'b0;
    // NUM_PE enabled idle cycles let the last product reach PE3 before the drain starts
    repeat (NUM_PE) begin
      drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      expect_quiet("out_valid rose before the drain was requested");
    end
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, '0);
    expect_quiet("out_valid rose in the cycle of the drain request");
    // The word is due NUM_PE cycles after the pulse, later when ena drops part way through
    while (!got_word && waited < WAIT_LIMIT) begin
      if (waited >= 2 && stall_left > 0) begin
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
        stall_left--;
      end else begin
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      end
      @(negedge clk);
      if (out_valid) begin
        got_word = 1'b1;
        if (out_data !== expected) begin
          $display("FAIL %s: out_data expected %h observed %h", test_name, expected, out_data);
          test_errors++;
        end
      end
      waited++;
    end
    if (!got_word) begin
      $display("ERROR %s: no output word arrived within %0d cycles of the drain",
               test_name, WAIT_LIMIT);
      test_errors++;
    end
    // The row keeps shifting zeros for one more edge, and no further word may follow
    repeat (NUM_PE) begin
      drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      expect_quiet("a second out_valid appeared within one drain");
    end
  endtask

  initial begin
    int                    fd;
    int                    n;
    int                    count;
    string                 line;
    string                 name;
    string                 cmd;
    logic [WORD_WIDTH-1:0] value;
    logic [WORD_WIDTH-1:0] extra;
    test_name    = "reset";
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    ena          = 1'b0;
    w_load       = 1'b0;
    w_data       = '0;
    a_valid      = 1'b0;
    a_data       = '0;
    drain        = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    // Nothing has been drained yet, so out_valid must stay low
    repeat (NUM_PE + 2) begin
      drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      expect_quiet("out_valid rose after reset with no drain");
    end
    close_test();

    fd = $fopen("tests/pe_drain_input.txt", "r");
    if (fd == 0) begin
      $display("ERROR: the command file could not be opened");
      total_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Blank lines and lines opening with # carry no command
        if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
          count = $sscanf(line, "%s %s %h %h", name, cmd, value, extra);
          if (count != 4) begin
            $display("ERROR: a command line could not be parsed: %s", line);
            total_errors++;
          end else begin
            test_name = name;
            if (cmd == "W") begin
              drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, value[OPERAND_WIDTH-1:0]);
              expect_quiet("out_valid rose during a weight load");
            end else if (cmd == "A") begin
              drive_cycle(1'b1, 1'b0, 1'b1, 1'b0, value[OPERAND_WIDTH-1:0]);
              expect_quiet("out_valid rose during the activation stream");
            end else if (cmd == "S") begin
              repeat (int'(value)) begin
                drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
                expect_quiet("out_valid rose while ena was low");
              end
            end else if (cmd == "D") begin
              run_drain(value, int'(extra));
            end else if (cmd == "E") begin
              close_test();
            end else begin
              $display("ERROR %s: unknown command %s", test_name, cmd);
              test_errors++;
            end
          end
        end
      end
      $fclose(fd);
    end

    // Errors of a test left open at the end of the file still count
    total_errors += test_errors;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/pe_drain_input.txt
# Columns: test name, command, value (hex), extra (hex)
# W weight, A activation, S ena-low cycles, D expected word with extra = ena-low cycles mid-drain, E end
load   W 04 0
load   W 08 0
load   W 0c 0
load   W 10 0
load   A 05 0
load   D 050a0f14 0
load   E 0 0
signed W fe 0
signed W 03 0
signed W 07 0
signed W f9 0
signed A 14 0
signed A fb 0
signed A 06 0
signed D f50f24db 0
signed E 0 0
sat    W 7f 0
sat    W 80 0
sat    W 01 0
sat    W ff 0
sat    A 7f 0
sat    A 7f 0
sat    D 7f803fc0 0
sat    E 0 0
clear  D 00000000 0
clear  E 0 0
stall  W 02 0
stall  W 04 0
stall  W 06 0
stall  W 08 0
stall  A 03 0
stall  S 3 0
stall  A 05 0
stall  A ff 0
stall  S 2 0
stall  D 03070a0e 3
stall  E 0 0

// File: sim.f
src/arith_pkg.sv
src/array_pkg.sv
src/mac_pe.sv
src/pe_row.sv
src/result_trunc.sv
src/pe_packer.sv
src/pe_drain_top.sv
tests/tb_pe_drain_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_pe_drain_top
FILELIST  ?= sim.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
